// ==== hdl/rv_pkg.sv ====
// shared widths, reset pc, opcode/class/alu/fetch enums
// AXI4-Lite read channel and retire structs for the rv32i core
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc    = 32'h8000_0000;
    localparam logic [2:0]      arprot_inst = 3'b100;  // unprivileged, secure, instruction

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_u,
        type_j,
        type_b,
        type_n  // unsupported, retires as nop
    } inst_type_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic {
        st_addr,
        st_data
    } fetch_state_e;

    typedef struct packed {
        logic [xlen-1:0] araddr;
        logic [2:0]      arprot;
        logic            arvalid;
    } axil_ar_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            rvalid;
    } axil_r_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [2:0]            funct3;
        inst_type_e            inst_type;
        alu_op_e               alu_op;
        logic                  is_lui;   // else auipc for type_u
        logic                  is_jalr;
        logic [xlen-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       next_pc;
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
    } retire_t;

endpackage

// ==== hdl/alu.sv ====
// integer alu: add/sub, shifts, set-less-than, logic ops
`timescale 1ns/10ps

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         op,
    output logic [rv_pkg::xlen-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shift amount

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== hdl/fetch_unit.sv ====
// program counter and AXI4-Lite read master for instruction fetch
`timescale 1ns/10ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    output rv_pkg::axil_ar_t      ar,
    input  logic                  arready,
    input  rv_pkg::axil_r_t       r,
    output logic                  rready,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] inst,
    output logic                  inst_valid
);
    import rv_pkg::*;

    fetch_state_e    state;
    logic            arvalid_q;
    logic [xlen-1:0] pc_q;

    assign ar.araddr  = pc_q;  // held until the R handshake
    assign ar.arprot  = arprot_inst;
    assign ar.arvalid = arvalid_q;

    assign rready     = (state == st_data);
    assign inst_valid = r.rvalid && rready;
    assign inst       = inst_valid ? r.rdata : '0;  // zero word decodes as nop
    assign pc         = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_addr;
            arvalid_q <= 1'b0;
            pc_q      <= reset_pc;
        end else begin
            case (state)
                st_addr: begin
                    if (arvalid_q && arready) begin
                        arvalid_q <= 1'b0;
                        state     <= st_data;
                    end else begin
                        arvalid_q <= 1'b1;  // first request after reset
                    end
                end
                st_data: begin
                    if (inst_valid) begin  // execute cycle
                        pc_q      <= next_pc;
                        arvalid_q <= 1'b1;
                        state     <= st_addr;
                    end
                end
                default: state <= st_addr;
            endcase
        end
    end

    // a pending request keeps its address until accepted
    assert property (@(posedge clk) disable iff (reset)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else $error("araddr changed while arvalid waited");

    // next_pc from execute must keep the pc on a word boundary
    assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc_q);

endmodule

// ==== hdl/decoder.sv ====
// instruction decoder: fields, class, immediate and alu operation
`timescale 1ns/10ps

module decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::decoded_t        dec
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.funct3  = funct3;
        dec.is_lui  = (opcode == lui);
        dec.is_jalr = (opcode == jalr);

        case (opcode)
            op:          dec.inst_type = type_r;
            op_imm, jalr: dec.inst_type = type_i;
            lui, auipc:  dec.inst_type = type_u;
            jal:         dec.inst_type = type_j;
            branch:      dec.inst_type = type_b;
            default:     dec.inst_type = type_n;  // loads, stores, system
        endcase

        case (dec.inst_type)
            type_i:  dec.imm = {{20{inst[31]}}, inst[31:20]};
            type_u:  dec.imm = {inst[31:12], 12'b0};
            type_j:  dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            type_b:  dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: dec.imm = '0;
        endcase

        dec.alu_op = alu_add;  // address and target arithmetic
        if (opcode == op || opcode == op_imm) begin
            case (funct3)
                3'b000:  dec.alu_op = (opcode == op && funct7[5]) ? alu_sub : alu_add;
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;  // srai has bit 30 too
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
// 32 x 32 register file, two combinational reads, one clocked write
`timescale 1ns/10ps

module reg_file (
    input  logic                          clk,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 reads as zero
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // execute must never target x0
    assert property (@(posedge clk) !(we && waddr == '0))
        else $error("write to x0 requested");

endmodule

// ==== hdl/execute_unit.sv ====
// execute stage: operand select, branch compare, next pc and write-back
`timescale 1ns/10ps

module execute_unit (
    input  rv_pkg::decoded_t        dec,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output rv_pkg::retire_t         retire
);
    import rv_pkg::*;

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_plus4;
    logic            taken;
    logic            is_jump;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign pc_plus4 = pc + 32'd4;
    assign is_jump  = (dec.inst_type == type_j) || dec.is_jalr;

    always_comb begin
        case (dec.inst_type)
            type_r: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            type_i: begin  // op_imm and jalr
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
            type_u: begin
                alu_a = dec.is_lui ? '0 : pc;
                alu_b = dec.imm;
            end
            default: begin  // jal, branch target
                alu_a = pc;
                alu_b = dec.imm;
            end
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        retire.pc = pc;
        retire.rd = dec.rd;

        if (dec.is_jalr) begin
            retire.next_pc = {alu_result[xlen-1:1], 1'b0};
        end else if (dec.inst_type == type_j || (dec.inst_type == type_b && taken)) begin
            retire.next_pc = alu_result;
        end else begin
            retire.next_pc = pc_plus4;
        end

        retire.we = (dec.rd != '0) && (dec.inst_type inside {type_r, type_i, type_u, type_j});
        retire.wdata = is_jump ? pc_plus4 : alu_result;  // link value for jumps
    end

    // program targets must stay word aligned
    always_comb begin
        if (!$isunknown(pc)) begin
            assert final (retire.next_pc[1:0] == 2'b00)
                else $error("misaligned next_pc %h at pc %h", retire.next_pc, pc);
        end
    end

endmodule

// ==== hdl/rv_core.sv ====
// rv32i core top: fetch, decode, register file and execute
`timescale 1ns/10ps

module rv_core (
    input  logic             clk,
    input  logic             reset,
    output rv_pkg::axil_ar_t ar,
    input  logic             arready,
    input  rv_pkg::axil_r_t  r,
    output logic             rready,
    output rv_pkg::retire_t  retire,
    output logic             retire_valid
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            inst_valid;
    decoded_t        dec;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready),
        .next_pc    (retire.next_pc),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .we     (retire.we),     // low outside the execute cycle
        .waddr  (retire.rd),
        .wdata  (retire.wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_unit u_execute (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rdata1),
        .rs2_data (rdata2),
        .retire   (retire)
    );

    assign retire_valid = inst_valid;  // one pulse per instruction

endmodule

// ==== tb/golden_model.svh ====
// program generator for the 64-word test program and the reference rv32i model
// used by the testbench checks to predict each retired instruction
`ifndef GOLDEN_MODEL_SVH
`define GOLDEN_MODEL_SVH

localparam int prog_words = 64;

logic [31:0] prog [prog_words];
logic [31:0] model_regs [32];

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] random_alu();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom_range(7));
    rd  = 5'($urandom_range(13));  // x0..x13, all written by the directed part
    rs1 = 5'($urandom_range(13));
    rs2 = 5'($urandom_range(13));
    alt = (f3 == 3'b000 || f3 == 3'b101) && ($urandom_range(1) == 1);
    if ($urandom_range(1) == 1) begin
        return enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
    end
    imm = 12'($urandom);
    if (f3 == 3'b001 || f3 == 3'b101) begin
        imm = {1'b0, alt, 5'b0, rs2};  // shamt form
    end
    return enc_i(imm, rs1, f3, rd, 7'b0010011);
endfunction

task automatic build_program();
    int          i;
    logic [31:0] filler;
    filler  = enc_i(12'd1, 5'd0, 3'b000, 5'd10, 7'b0010011);  // addi x10, x0, 1
    prog[0] = {20'h12345, 5'd1, 7'b0110111};                  // lui x1
    prog[1] = {20'h00001, 5'd2, 7'b0010111};                  // auipc x2
    prog[2] = enc_i(12'hffb, 5'd0, 3'b000, 5'd3, 7'b0010011); // x3 = -5
    prog[3] = enc_i(12'd7, 5'd0, 3'b000, 5'd4, 7'b0010011);   // x4 = 7
    prog[4] = enc_r(7'h20, 5'd3, 5'd4, 3'b000, 5'd5);         // sub
    prog[5] = enc_r(7'h20, 5'd4, 5'd3, 3'b101, 5'd6);         // sra
    prog[6] = enc_r(7'h00, 5'd4, 5'd3, 3'b101, 5'd7);         // srl
    prog[7] = enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd8);         // slt
    prog[8] = enc_r(7'h00, 5'd4, 5'd3, 3'b011, 5'd9);         // sltu
    prog[9] = enc_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd0);         // add to x0
    i = 10;
    // two operand pairs per branch give one taken and one not taken case
    for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
            prog[i]     = enc_b(13'd8, 5'd4, (f < 2) ? 5'd4 : 5'd3, 3'(f));
            prog[i + 1] = filler;
            prog[i + 2] = enc_b(13'd8, (f < 2) ? 5'd4 : 5'd3, (f < 2) ? 5'd3 : 5'd4, 3'(f));
            prog[i + 3] = filler;
            i += 4;
        end
    end
    prog[34] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd11, 7'b1101111};   // jal x11, +8
    prog[35] = filler;
    prog[36] = {20'h0, 5'd12, 7'b0010111};                      // auipc x12, 0
    prog[37] = enc_i(12'd13, 5'd12, 3'b000, 5'd13, 7'b1100111); // odd target, lands on 39
    prog[38] = filler;
    for (int k = 39; k < prog_words - 1; k++) begin
        prog[k] = random_alu();
    end
    prog[prog_words - 1] = {20'h0, 5'd0, 7'b1101111};  // jal x0, 0
endtask

function automatic logic [31:0] prog_word(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - rv_pkg::reset_pc;
    return prog[offset[7:2]];
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    logic [31:0] fill;
    fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;  // sign bits shifted in by sra
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? ((a >> b[4:0]) | fill) : (a >> b[4:0]);
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic rv_pkg::retire_t ref_step(logic [31:0] pc, logic [31:0] w);
    rv_pkg::retire_t e;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm_i;
    logic [2:0]      f3;
    logic            taken;
    a         = model_regs[w[19:15]];
    b         = model_regs[w[24:20]];
    f3        = w[14:12];
    imm_i     = {{20{w[31]}}, w[31:20]};
    e.pc      = pc;
    e.next_pc = pc + 4;
    e.rd      = w[11:7];
    e.we      = 1'b1;
    e.wdata   = pc + 4;  // link value unless replaced
    case (w[6:0])
        7'b0110011: e.wdata = alu_ref(f3, w[30], a, b);
        7'b0010011: e.wdata = alu_ref(f3, w[30] && f3 == 3'b101, a, imm_i);
        7'b0110111: e.wdata = {w[31:12], 12'b0};
        7'b0010111: e.wdata = pc + {w[31:12], 12'b0};
        7'b1101111: e.next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        7'b1100111: e.next_pc = (a + imm_i) & ~32'd1;
        7'b1100011: begin
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                3'b111:  taken = (a >= b);
                default: taken = 1'b0;
            endcase
            e.we = 1'b0;
            if (taken) begin
                e.next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        default: e.we = 1'b0;  // dropped opcodes retire as nops
    endcase
    e.we = e.we && (e.rd != 5'd0);
    return e;
endfunction

`endif

// ==== tb/tb_rv_core.sv ====
// testbench for the rv32i core with clock, reset and an AXI4-Lite instruction memory
// with random stalls, checks against the reference model and a timeout
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    `include "golden_model.svh"

    localparam int drive_delay  = 10;
    localparam int reset_cycles = 10;
    localparam int loop_retires = 3;
    localparam int max_cycles   = (prog_words + loop_retires) * 10 + reset_cycles;

    logic     clk     = 1'b0;
    logic     reset   = 1'b1;
    logic     arready = 1'b0;
    axil_r_t  r       = '0;
    axil_ar_t ar;
    logic     rready;
    retire_t  retire;
    logic     retire_valid;

    logic        ar_fire;
    logic        r_fire;
    logic [31:0] fire_addr;
    logic [31:0] r_addr;
    logic        r_pending;
    logic [7:0]  fetch_count;
    int          ar_stall;
    int          r_stall;
    int          ar_stall_tab [256];
    int          r_stall_tab [256];

    logic [31:0] model_pc;
    retire_t     exp_ret;
    logic [31:0] last_next_pc;
    logic        seen_retire;

    int    error_count       = 0;
    int    test_start_errors = 0;
    int    test_retires      = 0;
    int    loop_count        = 0;
    int    finish_id         = -1;
    int    tests_passed      = 0;
    int    tests_failed      = 0;
    int    cycles            = 0;
    logic  done              = 1'b0;
    string test_names [5]    = '{"alu and upper immediates", "branches", "jumps",
                                 "random alu", "self loop"};

    rv_core UUT (
        .clk          (clk),
        .reset        (reset),
        .ar           (ar),
        .arready      (arready),
        .r            (r),
        .rready       (rready),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    always #50 clk = ~clk;

    task automatic value_error(string name, logic [31:0] expected, logic [31:0] actual);
        error_count++;
        $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic note_failure(string what);
        error_count++;
        $display("failure at %0t: %s", $time, what);
    endtask

    function automatic int test_of(logic [31:0] pc);
        logic [31:0] idx;
        idx = (pc - reset_pc) >> 2;
        if (idx < 10) return 0;
        if (idx < 34) return 1;
        if (idx < 39) return 2;
        if (idx < 63) return 3;
        return 4;
    endfunction

    // AXI4-Lite read slave sampling handshakes on the edge
    always @(posedge clk) begin
        ar_fire   = ar.arvalid && arready;
        r_fire    = r.rvalid && rready;
        fire_addr = ar.araddr;
        #drive_delay;
        if (reset) begin
            arready     = 1'b0;
            r           = '0;
            r_pending   = 1'b0;
            fetch_count = '0;
            ar_stall    = ar_stall_tab[0];
        end else begin
            if (r_fire) begin
                r.rvalid = 1'b0;
            end
            if (ar_fire) begin
                arready     = 1'b0;
                r_pending   = 1'b1;
                r_addr      = fire_addr;
                r_stall     = r_stall_tab[fetch_count];
                fetch_count = fetch_count + 1'b1;
                ar_stall    = ar_stall_tab[fetch_count];
            end else if (ar.arvalid && !arready) begin
                if (ar_stall == 0) begin
                    arready = 1'b1;
                end else begin
                    ar_stall--;
                end
            end
            if (r_pending) begin
                if (r_stall == 0) begin
                    r.rvalid  = 1'b1;
                    r.rdata   = prog_word(r_addr);
                    r_pending = 1'b0;
                end else begin
                    r_stall--;
                end
            end
        end
    end

    // reference model steps on every retire
    always @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                model_regs[k] = '0;
            end
            model_pc    = reset_pc;
            seen_retire = 1'b0;
            loop_count  = 0;
            exp_ret     = ref_step(model_pc, prog_word(model_pc));
        end else if (retire_valid) begin
            if (exp_ret.we) begin
                model_regs[exp_ret.rd] = exp_ret.wdata;
            end
            last_next_pc = retire.next_pc;
            seen_retire  = 1'b1;
            model_pc     = exp_ret.next_pc;
            test_retires++;
            if (test_of(exp_ret.pc) == 4) begin
                loop_count++;
            end
            if (test_of(model_pc) != test_of(exp_ret.pc) || loop_count == loop_retires) begin
                finish_id = test_of(exp_ret.pc);
            end
            exp_ret = ref_step(model_pc, prog_word(model_pc));
        end
    end

    // test summary half a cycle after the checks of that edge
    always @(negedge clk) begin
        if (finish_id >= 0) begin
            if (error_count == test_start_errors) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
            $display("test %0d (%s): %0d instructions retired, %0d errors", finish_id,
                     test_names[finish_id], test_retires, error_count - test_start_errors);
            test_start_errors = error_count;
            test_retires      = 0;
            done              = (finish_id == 4);
            finish_id         = -1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) retire_valid |-> retire.pc == exp_ret.pc)
        else value_error("retire.pc", $sampled(exp_ret.pc), $sampled(retire.pc));

    assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire.next_pc == exp_ret.next_pc)
        else value_error("retire.next_pc", $sampled(exp_ret.next_pc), $sampled(retire.next_pc));

    assert property (@(posedge clk) disable iff (reset) retire_valid |-> retire.we == exp_ret.we)
        else value_error("retire.we", 32'($sampled(exp_ret.we)), 32'($sampled(retire.we)));

    assert property (@(posedge clk) disable iff (reset) retire_valid |-> retire.rd == exp_ret.rd)
        else value_error("retire.rd", 32'($sampled(exp_ret.rd)), 32'($sampled(retire.rd)));

    assert property (@(posedge clk) disable iff (reset)
        retire_valid && exp_ret.we |-> retire.wdata == exp_ret.wdata)
        else value_error("retire.wdata", $sampled(exp_ret.wdata), $sampled(retire.wdata));

    // each retired pc follows the next_pc the core reported before
    assert property (@(posedge clk) disable iff (reset)
        retire_valid && seen_retire |-> retire.pc == last_next_pc)
        else value_error("retire.pc", $sampled(last_next_pc), $sampled(retire.pc));

    assert property (@(posedge clk) disable iff (reset)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else note_failure("read address changed or was withdrawn before arready");

    assert property (@(posedge clk) disable iff (reset)
        ar.arvalid |-> (ar.araddr - reset_pc) < prog_words * 4)
        else note_failure("instruction fetch outside the test program");

    // unprivileged secure instruction access
    assert property (@(posedge clk) disable iff (reset) ar.arvalid |-> ar.arprot == 3'b100)
        else value_error("ar.arprot", 32'h4, 32'($sampled(ar.arprot)));

    // rready follows the AR handshake and holds until the R handshake
    assert property (@(posedge clk) disable iff (reset)
        (ar.arvalid && arready) || (rready && !r.rvalid) |=> rready)
        else note_failure("rready dropped before the read data arrived");

    assert property (@(posedge clk) disable iff (reset) !(ar.arvalid && rready))
        else note_failure("address and data requested together");

    assert property (@(posedge clk) reset |=> !ar.arvalid && !rready && !retire_valid)
        else note_failure("arvalid, rready or retire_valid high after a reset cycle");

    initial begin
        void'($urandom(32'h6322ec2b));
        build_program();
        for (int k = 0; k < 256; k++) begin
            ar_stall_tab[k] = $urandom_range(3);
            r_stall_tab[k]  = $urandom_range(3);
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset  = 1'b0;
        cycles = reset_cycles;
        while (!done && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (!done) begin
            tests_failed++;
            $display("timeout: the program did not finish within %0d cycles", max_cycles);
        end
        $display("%0d tests passed, %0d tests failed, %0d check errors", tests_passed,
                 tests_failed, error_count);
        if (done && tests_failed == 0 && error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+tb
hdl/rv_pkg.sv
hdl/alu.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/rv_core.sv
tb/tb_rv_core.sv
